// ==== src/tcdm_pkg.sv ====
// TCDM scratchpad shared definitions
// data and byte-enable widths, bank geometry
// word-interleaved byte address union

package tcdm_pkg;

    // ----------------------------------------------------------------------
    // geometry
    // ----------------------------------------------------------------------
    localparam int unsigned DATA_WIDTH     = 32;
    localparam int unsigned BE_WIDTH       = DATA_WIDTH / 8;
    localparam int unsigned NUM_BANKS      = 4;
    localparam int unsigned BANK_SEL_WIDTH = $clog2(NUM_BANKS);
    localparam int unsigned ROW_WIDTH      = 8;
    localparam int unsigned NUM_ROWS       = 2 ** ROW_WIDTH;  // words per bank
    localparam int unsigned OFF_WIDTH      = $clog2(BE_WIDTH);
    localparam int unsigned ADDR_WIDTH     = ROW_WIDTH + BANK_SEL_WIDTH + OFF_WIDTH;

    // ----------------------------------------------------------------------
    // basic types
    // ----------------------------------------------------------------------
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [BE_WIDTH-1:0]       be_t;
    typedef logic [ROW_WIDTH-1:0]      row_t;
    typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;

    // low bits pick the bank, so consecutive words land in consecutive banks
    typedef struct packed {
        row_t                  row;
        bank_sel_t             bank;
        logic [OFF_WIDTH-1:0]  byte_off;  // word aligned only
    } tcdm_addr_fields_t;

    // same 12 bits, seen as the master drives them or split for decode
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        tcdm_addr_fields_t     fields;
    } tcdm_addr_u;

endpackage : tcdm_pkg

// ==== src/tcdm_rr_arbiter.sv ====
// round-robin arbiter for one TCDM bank
// combinational one-hot grant, rotating priority pointer

`timescale 1ns/1ps

module tcdm_rr_arbiter #(
    parameter  int unsigned NumIn    = 4,
    localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [NumIn-1:0]    req_i,
    output logic [NumIn-1:0]    gnt_o,
    output logic [IdxWidth-1:0] idx_o
);

    logic [IdxWidth-1:0] ptr_q;  // highest priority master
    logic [IdxWidth-1:0] ptr_d;

    // ----------------------------------------------------------------------
    // winner search, cyclic from the pointer
    // ----------------------------------------------------------------------
    always_comb begin : pick
        logic        found;
        int unsigned cand;
        found = 1'b0;
        cand  = 0;
        gnt_o = '0;
        idx_o = ptr_q;
        for (int unsigned off = 0; off < NumIn; off++) begin
            cand = (int'(ptr_q) + off) % NumIn;
            if (!found && req_i[cand]) begin
                found       = 1'b1;
                gnt_o[cand] = 1'b1;
                idx_o       = IdxWidth'(cand);
            end
        end
    end

    // winner + 1, wrapping at NumIn
    assign ptr_d = (idx_o == IdxWidth'(NumIn - 1)) ? '0 : idx_o + IdxWidth'(1);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (|gnt_o) begin
            ptr_q <= ptr_d;
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // at most one winner, and only among the masters asking for the bank
    a_gnt_legal : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0)
    );

endmodule : tcdm_rr_arbiter

// ==== src/tcdm_interconnect.sv ====
// TCDM bank-level interconnect
// address decode, per-bank round-robin arbitration,
// request muxing toward banks and response routing back

`timescale 1ns/1ps

module tcdm_interconnect #(
    parameter int unsigned NumIn = 4
) (
    input  logic                                           clk_i,
    input  logic                                           rst_n_i,

    // master side
    input  logic               [NumIn-1:0]                 req_i,
    input  tcdm_pkg::tcdm_addr_u [NumIn-1:0]               addr_i,
    input  logic               [NumIn-1:0]                 we_i,
    input  tcdm_pkg::data_t    [NumIn-1:0]                 wdata_i,
    input  tcdm_pkg::be_t      [NumIn-1:0]                 be_i,
    output logic               [NumIn-1:0]                 gnt_o,
    output logic               [NumIn-1:0]                 vld_o,
    output tcdm_pkg::data_t    [NumIn-1:0]                 rdata_o,

    // bank side
    output logic               [tcdm_pkg::NUM_BANKS-1:0]   bank_req_o,
    output tcdm_pkg::row_t     [tcdm_pkg::NUM_BANKS-1:0]   bank_row_o,
    output logic               [tcdm_pkg::NUM_BANKS-1:0]   bank_we_o,
    output tcdm_pkg::data_t    [tcdm_pkg::NUM_BANKS-1:0]   bank_wdata_o,
    output tcdm_pkg::be_t      [tcdm_pkg::NUM_BANKS-1:0]   bank_be_o,
    input  tcdm_pkg::data_t    [tcdm_pkg::NUM_BANKS-1:0]   bank_rdata_i
);

    import tcdm_pkg::*;

    localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

    bank_sel_t [NumIn-1:0]                     sel;        // decoded bank per master
    logic      [NUM_BANKS-1:0][NumIn-1:0]      bank_reqs;
    logic      [NUM_BANKS-1:0][NumIn-1:0]      bank_gnt;
    logic      [NUM_BANKS-1:0][IdxWidth-1:0]   bank_idx;   // winner per bank
    logic      [NumIn-1:0][NUM_BANKS-1:0]      gnt_col;    // grants seen by a master

    logic      [NumIn-1:0]                     pend_q;     // response due next cycle
    bank_sel_t [NumIn-1:0]                     bank_q;     // bank that owes it

    // ----------------------------------------------------------------------
    // decode and per-bank request vectors
    // ----------------------------------------------------------------------
    for (genvar m = 0; m < NumIn; m++) begin : g_decode
        assign sel[m] = addr_i[m].fields.bank;

        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_col
            assign bank_reqs[b][m] = req_i[m] && (sel[m] == bank_sel_t'(b));
            assign gnt_col[m][b]   = bank_gnt[b][m];
        end

        assign gnt_o[m] = |gnt_col[m];
    end

    // ----------------------------------------------------------------------
    // arbitration and request mux per bank
    // ----------------------------------------------------------------------
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        tcdm_rr_arbiter #(
            .NumIn (NumIn)
        ) u_arb (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (bank_reqs[b]),
            .gnt_o   (bank_gnt[b]),
            .idx_o   (bank_idx[b])
        );

        assign bank_req_o[b]   = |bank_gnt[b];
        assign bank_row_o[b]   = addr_i[bank_idx[b]].fields.row;
        assign bank_we_o[b]    = we_i[bank_idx[b]];
        assign bank_wdata_o[b] = wdata_i[bank_idx[b]];
        assign bank_be_o[b]    = be_i[bank_idx[b]];
    end

    // ----------------------------------------------------------------------
    // response routing, one cycle after the grant
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= gnt_o;  // reads and writes both answer
        end
    end

    for (genvar m = 0; m < NumIn; m++) begin : g_rsp
        always_ff @(posedge clk_i) begin
            if (gnt_o[m]) begin
                bank_q[m] <= sel[m];
            end
        end

        assign vld_o[m]   = pend_q[m];
        assign rdata_o[m] = bank_rdata_i[bank_q[m]];  // only meaningful on reads

        // ------------------------------------------------------------------
        // checks
        // ------------------------------------------------------------------
        // no two bank arbiters pick the same master in one cycle
        a_single_bank_gnt : assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            $onehot0(gnt_col[m])
        );

        // a response needs a bank access steered to this master one cycle earlier
        a_vld_after_gnt : assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            vld_o[m] |-> $past(bank_req_o[sel[m]] && (bank_idx[sel[m]] == IdxWidth'(m)))
        );
    end

endmodule : tcdm_interconnect

// ==== src/tcdm_sram_bank.sv ====
// single-port SRAM bank for the TCDM
// byte-enable writes, one-cycle registered read

`timescale 1ns/1ps

module tcdm_sram_bank (
    input  logic            clk_i,
    input  logic            req_i,
    input  tcdm_pkg::row_t  row_i,
    input  logic            we_i,
    input  tcdm_pkg::data_t wdata_i,
    input  tcdm_pkg::be_t   be_i,
    output tcdm_pkg::data_t rdata_o
);

    import tcdm_pkg::*;

    data_t mem [NUM_ROWS];  // 256 words

    // ----------------------------------------------------------------------
    // write merges enabled bytes, read lands on rdata_o next cycle
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                for (int unsigned i = 0; i < BE_WIDTH; i++) begin
                    if (be_i[i]) begin
                        mem[row_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[row_i];
            end
        end
    end

endmodule : tcdm_sram_bank

// ==== src/tcdm_subsystem_top.sv ====
// TCDM subsystem top level
// interconnect plus word-interleaved SRAM banks

`timescale 1ns/1ps

module tcdm_subsystem_top #(
    parameter int unsigned NumIn = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                 [NumIn-1:0] req_i,
    input  tcdm_pkg::tcdm_addr_u [NumIn-1:0] addr_i,
    input  logic                 [NumIn-1:0] we_i,
    input  tcdm_pkg::data_t      [NumIn-1:0] wdata_i,
    input  tcdm_pkg::be_t        [NumIn-1:0] be_i,
    output logic                 [NumIn-1:0] gnt_o,
    output logic                 [NumIn-1:0] vld_o,
    output tcdm_pkg::data_t      [NumIn-1:0] rdata_o
);

    import tcdm_pkg::*;

    // interconnect to banks
    logic  [NUM_BANKS-1:0] bank_req;
    row_t  [NUM_BANKS-1:0] bank_row;
    logic  [NUM_BANKS-1:0] bank_we;
    data_t [NUM_BANKS-1:0] bank_wdata;
    be_t   [NUM_BANKS-1:0] bank_be;
    data_t [NUM_BANKS-1:0] bank_rdata;

    tcdm_interconnect #(
        .NumIn (NumIn)
    ) u_xbar (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .we_i         (we_i),
        .wdata_i      (wdata_i),
        .be_i         (be_i),
        .gnt_o        (gnt_o),
        .vld_o        (vld_o),
        .rdata_o      (rdata_o),
        .bank_req_o   (bank_req),
        .bank_row_o   (bank_row),
        .bank_we_o    (bank_we),
        .bank_wdata_o (bank_wdata),
        .bank_be_o    (bank_be),
        .bank_rdata_i (bank_rdata)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        tcdm_sram_bank u_bank (
            .clk_i   (clk_i),
            .req_i   (bank_req[b]),
            .row_i   (bank_row[b]),
            .we_i    (bank_we[b]),
            .wdata_i (bank_wdata[b]),
            .be_i    (bank_be[b]),
            .rdata_o (bank_rdata[b])
        );
    end

endmodule : tcdm_subsystem_top

// ==== verif/tb_tcdm_top.sv ====
// testbench for the TCDM subsystem
// stimulus table applied row by row, flat reference memory,
// round-robin grant model, compare tasks and watchdog

`timescale 1ns/1ps

module tb_tcdm_top;

    import tcdm_pkg::*;

    localparam int unsigned NumIn       = 4;
    localparam int unsigned ClkPeriod   = 40;
    localparam int unsigned ResetCycles = 16;
    localparam int unsigned MaxRows     = 64;
    localparam int unsigned NumWords    = NUM_BANKS * NUM_ROWS;

    logic                   clk_i;
    logic                   rst_n_i;
    logic       [NumIn-1:0] req_i;
    tcdm_addr_u [NumIn-1:0] addr_i;
    logic       [NumIn-1:0] we_i;
    data_t      [NumIn-1:0] wdata_i;
    be_t        [NumIn-1:0] be_i;
    logic       [NumIn-1:0] gnt_o;
    logic       [NumIn-1:0] vld_o;
    data_t      [NumIn-1:0] rdata_o;

    // ----------------------------------------------------------------------
    // stimulus table, one row per step
    // ----------------------------------------------------------------------
    logic [NumIn-1:0]      tbl_req   [MaxRows];
    logic [NumIn-1:0]      tbl_we    [MaxRows];
    logic [ADDR_WIDTH-1:0] tbl_addr  [MaxRows][NumIn];
    data_t                 tbl_wdata [MaxRows][NumIn];
    be_t                   tbl_be    [MaxRows][NumIn];
    int unsigned           n_rows;
    bit                    table_built;

    // reference model state
    data_t            ref_mem   [NumWords];  // flat word-addressed view
    int unsigned      ptr_model [NUM_BANKS];
    logic [NumIn-1:0] exp_vld;
    logic [NumIn-1:0] exp_rd;                // pending response is a read
    data_t            exp_rdata [NumIn];

    int unsigned n_checks;
    int unsigned n_mismatch;
    int unsigned n_other;

    tcdm_subsystem_top #(
        .NumIn (NumIn)
    ) DUT (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .addr_i  (addr_i),
        .we_i    (we_i),
        .wdata_i (wdata_i),
        .be_i    (be_i),
        .gnt_o   (gnt_o),
        .vld_o   (vld_o),
        .rdata_o (rdata_o)
    );

    initial begin : clock
        clk_i = 1'b0;
        forever #(ClkPeriod / 2) clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // address rules and byte merge
    // ----------------------------------------------------------------------
    function automatic int unsigned word_of(input logic [ADDR_WIDTH-1:0] a);
        return 32'(a) / BE_WIDTH;
    endfunction

    // consecutive words go to consecutive banks
    function automatic int unsigned bank_of(input logic [ADDR_WIDTH-1:0] a);
        return word_of(a) % NUM_BANKS;
    endfunction

    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
        data_t res;
        res = old_w;
        for (int unsigned i = 0; i < BE_WIDTH; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // first requester at or after each bank's pointer
    function automatic logic [NumIn-1:0] predict_grant(input logic [NumIn-1:0] req,
                                                       input int unsigned row);
        logic [NumIn-1:0] gnt;
        logic             found;
        int unsigned      m;
        gnt = '0;
        for (int unsigned b = 0; b < NUM_BANKS; b++) begin
            found = 1'b0;
            for (int unsigned k = 0; k < NumIn; k++) begin
                m = (ptr_model[b] + k) % NumIn;
                if (!found && req[m] && bank_of(tbl_addr[row][m]) == b) begin
                    found  = 1'b1;
                    gnt[m] = 1'b1;
                end
            end
        end
        return gnt;
    endfunction

    task automatic update_model(input logic [NumIn-1:0] gnt, input int unsigned row);
        int unsigned word;
        exp_vld = gnt;
        exp_rd  = '0;
        for (int unsigned b = 0; b < NUM_BANKS; b++) begin
            for (int unsigned m = 0; m < NumIn; m++) begin
                if (gnt[m] && bank_of(tbl_addr[row][m]) == b) begin
                    word = word_of(tbl_addr[row][m]);
                    if (tbl_we[row][m]) begin
                        ref_mem[word] = merge_bytes(ref_mem[word], tbl_wdata[row][m],
                                                    tbl_be[row][m]);
                    end else begin
                        exp_rd[m]    = 1'b1;
                        exp_rdata[m] = ref_mem[word];
                    end
                    ptr_model[b] = (m + 1) % NumIn;
                end
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_data(input string name, input data_t exp, input data_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_grant(input string name, input logic [NumIn-1:0] exp,
                               input logic [NumIn-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // ----------------------------------------------------------------------
    // table building
    // ----------------------------------------------------------------------
    task automatic put_lane(input int unsigned m, input int unsigned addr,
                            input logic we, input be_t be);
        tbl_req[n_rows][m]   = 1'b1;
        tbl_addr[n_rows][m]  = ADDR_WIDTH'(addr);
        tbl_we[n_rows][m]    = we;
        tbl_wdata[n_rows][m] = $urandom;
        tbl_be[n_rows][m]    = be;
    endtask

    task automatic close_row();
        if (n_rows == MaxRows - 1) begin
            n_other++;
            $display("stimulus table is full, later rows overwrite the last one");
        end else begin
            n_rows++;
        end
    endtask

    task automatic build_table();
        n_rows = 0;
        for (int unsigned r = 0; r < MaxRows; r++) begin
            tbl_req[r] = '0;
            tbl_we[r]  = '0;
            for (int unsigned m = 0; m < NumIn; m++) begin
                tbl_addr[r][m]  = '0;
                tbl_wdata[r][m] = '0;
                tbl_be[r][m]    = '0;
            end
        end
        close_row();  // idle after reset
        close_row();
        // background, each master on its own bank
        for (int unsigned r = 0; r < 16; r++) begin
            for (int unsigned m = 0; m < NumIn; m++) begin
                put_lane(m, r * 16 + m * 4, 1'b1, 4'hf);
            end
            close_row();
        end
        for (int unsigned r = 0; r < 4; r++) begin
            for (int unsigned m = 0; m < NumIn; m++) begin
                put_lane(m, 'hfc0 + r * 16 + m * 4, 1'b1, 4'hf);
            end
            close_row();
        end
        // single master write then read back
        put_lane(1, 'h044, 1'b1, 4'hf);
        close_row();
        put_lane(1, 'h044, 1'b0, 4'hf);
        close_row();
        put_lane(3, 'hfe0, 1'b1, 4'hf);
        close_row();
        put_lane(3, 'hfe0, 1'b0, 4'hf);
        close_row();
        // partial writes
        put_lane(0, 'h010, 1'b1, 4'b0101);
        put_lane(2, 'h028, 1'b1, 4'b1000);
        put_lane(3, 'h0f4, 1'b1, 4'b0110);
        close_row();
        put_lane(0, 'h010, 1'b0, 4'hf);
        put_lane(2, 'h028, 1'b0, 4'hf);
        put_lane(3, 'h0f4, 1'b0, 4'hf);
        close_row();
        put_lane(1, 'h010, 1'b1, 4'b1010);
        close_row();
        put_lane(2, 'h010, 1'b0, 4'hf);
        close_row();
        // four banks at once
        put_lane(0, 'h03c, 1'b0, 4'hf);
        put_lane(1, 'h030, 1'b0, 4'hf);
        put_lane(2, 'h034, 1'b0, 4'hf);
        put_lane(3, 'h038, 1'b0, 4'hf);
        close_row();
        // everybody on bank 1
        put_lane(0, 'h004, 1'b0, 4'hf);
        put_lane(1, 'h014, 1'b0, 4'hf);
        put_lane(2, 'h024, 1'b0, 4'hf);
        put_lane(3, 'hfd4, 1'b0, 4'hf);
        close_row();
        put_lane(1, 'h004, 1'b1, 4'hf);
        put_lane(2, 'h004, 1'b0, 4'hf);
        put_lane(3, 'h004, 1'b1, 4'b0011);
        close_row();
        put_lane(0, 'h004, 1'b0, 4'hf);
        close_row();
        // two on bank 2, the rest elsewhere
        put_lane(0, 'h008, 1'b1, 4'hf);
        put_lane(1, 'h00c, 1'b0, 4'hf);
        put_lane(2, 'h000, 1'b0, 4'hf);
        put_lane(3, 'h008, 1'b0, 4'hf);
        close_row();
        // everybody on bank 3, write then rotated read
        put_lane(0, 'h00c, 1'b1, 4'b1100);
        put_lane(1, 'h01c, 1'b1, 4'hf);
        put_lane(2, 'h02c, 1'b1, 4'b0001);
        put_lane(3, 'hfdc, 1'b1, 4'b0111);
        close_row();
        put_lane(0, 'hfdc, 1'b0, 4'hf);
        put_lane(1, 'h00c, 1'b0, 4'hf);
        put_lane(2, 'h01c, 1'b0, 4'hf);
        put_lane(3, 'h02c, 1'b0, 4'hf);
        close_row();
        // address pairs 4 bytes apart
        put_lane(0, 'h03c, 1'b0, 4'hf);
        put_lane(1, 'h040, 1'b0, 4'hf);
        put_lane(2, 'hfe4, 1'b0, 4'hf);
        put_lane(3, 'hfe8, 1'b0, 4'hf);
        close_row();
        put_lane(0, 'h0a0, 1'b0, 4'hf);
        put_lane(1, 'h0a4, 1'b0, 4'hf);
        put_lane(2, 'h0f8, 1'b0, 4'hf);
        put_lane(3, 'h0fc, 1'b0, 4'hf);
        close_row();
        close_row();  // drain the last response
    endtask

    // ----------------------------------------------------------------------
    // row driver, one cycle sampled at the falling edge
    // ----------------------------------------------------------------------
    task automatic sample_cycle(input int unsigned row, input logic [NumIn-1:0] waiting,
                                output logic [NumIn-1:0] act_gnt);
        logic [NumIn-1:0] exp_gnt;
        @(negedge clk_i);
        act_gnt = gnt_o;
        check_grant("vld_o", exp_vld, vld_o);
        for (int unsigned m = 0; m < NumIn; m++) begin
            if (exp_vld[m] && exp_rd[m]) begin
                check_data($sformatf("rdata_o[%0d]", m), exp_rdata[m], rdata_o[m]);
            end
        end
        exp_gnt = predict_grant(waiting, row);
        check_grant("gnt_o", exp_gnt, act_gnt);
        update_model(exp_gnt, row);
    endtask

    task automatic apply_row(input int unsigned row);
        logic [NumIn-1:0] waiting;
        logic [NumIn-1:0] granted;
        @(posedge clk_i);
        for (int unsigned m = 0; m < NumIn; m++) begin
            addr_i[m].raw <= tbl_addr[row][m];
            wdata_i[m]    <= tbl_wdata[row][m];
            be_i[m]       <= tbl_be[row][m];
        end
        req_i   <= tbl_req[row];
        we_i    <= tbl_we[row];
        waiting  = tbl_req[row];
        do begin
            sample_cycle(row, waiting, granted);
            waiting = waiting & ~granted;
            if (waiting != '0) begin
                @(posedge clk_i);
                req_i <= waiting;  // losers hold
            end
        end while (waiting != '0);
    endtask

    // ----------------------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin : main
        req_i      = '0;
        addr_i     = '0;
        we_i       = '0;
        wdata_i    = '0;
        be_i       = '0;
        rst_n_i    = 1'b0;
        n_checks   = 0;
        n_mismatch = 0;
        n_other    = 0;
        exp_vld    = '0;
        exp_rd     = '0;
        for (int unsigned b = 0; b < NUM_BANKS; b++) ptr_model[b] = 0;
        void'($urandom(32'hfd0a_c9b9));
        build_table();
        table_built = 1'b1;
        repeat (ResetCycles) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int unsigned r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_built);
        #((n_rows * (NumIn + 2) + ResetCycles + 2) * ClkPeriod);
        n_other++;
        $display("timeout: a request was not granted within %0d rows", n_rows);
        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 n_checks, n_mismatch, n_other);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_tcdm_top

// ==== tcdm_xbar.f ====
src/tcdm_pkg.sv
src/tcdm_rr_arbiter.sv
src/tcdm_interconnect.sv
src/tcdm_sram_bank.sv
src/tcdm_subsystem_top.sv
verif/tb_tcdm_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the TCDM testbench with Verilator and runs it
# the run fails if the log holds the fail status or the simulator stops early

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_tcdm_top \
    -Mdir obj_dir \
    -f tcdm_xbar.f \
    && ./obj_dir/Vtb_tcdm_top 2>&1 | tee "$LOG" \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "STATUS: FAIL" "$LOG" && { echo "simulation reported failure, see $LOG"; exit 1; }
grep -q "STATUS: PASS" "$LOG" || { echo "no final status in $LOG"; exit 1; }
exit 0
